// ==== Makefile ====
TOP := tb_exec_stage

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --timescale 1ns/100ps \
		-f riscv_exec.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
		echo "$$out"; \
		echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== alu.sv ====
`timescale 1ns/100ps

module alu import riscv_exec_pkg::*; (
    input  logic [xlen-1:0] a_i,
    input  logic [xlen-1:0] b_i,
    input  alu_op_e         op_i,
    output logic [xlen-1:0] result_o,
    output alu_flags_t      flags_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            op_add:    result_o = a_i + b_i;
            op_sub:    result_o = a_i - b_i;
            op_sll:    result_o = a_i << shamt;
            op_slt:    result_o = {{(xlen-1){1'b0}}, lt_s};
            op_sltu:   result_o = {{(xlen-1){1'b0}}, lt_u};
            op_xor:    result_o = a_i ^ b_i;
            op_srl:    result_o = a_i >> shamt;
            op_sra:    result_o = $unsigned($signed(a_i) >>> shamt);
            op_or:     result_o = a_i | b_i;
            op_and:    result_o = a_i & b_i;
            op_pass_b: result_o = b_i;
            default:   result_o = '0;
        endcase
    end

    // zero only means equal when the op is sub
    assign flags_o.zero = (result_o == '0);
    assign flags_o.lt   = lt_s;
    assign flags_o.ltu  = lt_u;

endmodule

// ==== alu_decoder.sv ====
`timescale 1ns/100ps

module alu_decoder import riscv_exec_pkg::*; (
    input  alu_class_e alu_class_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7_b5_i,
    input  logic       is_reg_op_i,  // R-type, may select sub
    output alu_op_e    alu_op_o
);

    always_comb begin
        case (alu_class_i)
            alu_add: alu_op_o = op_add;
            alu_cmp: alu_op_o = op_sub;
            alu_func: begin
                case (funct3_i)
                    3'b000:  alu_op_o = (is_reg_op_i && funct7_b5_i) ? op_sub : op_add;
                    3'b001:  alu_op_o = op_sll;
                    3'b010:  alu_op_o = op_slt;
                    3'b011:  alu_op_o = op_sltu;
                    3'b100:  alu_op_o = op_xor;
                    3'b101:  alu_op_o = funct7_b5_i ? op_sra : op_srl;  // srai too
                    3'b110:  alu_op_o = op_or;
                    default: alu_op_o = op_and;
                endcase
            end
            default: alu_op_o = op_pass_b;
        endcase
    end

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage import riscv_exec_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            instr_valid_i,
    input  instr_u          instr_i,
    input  logic [xlen-1:0] pc_i,
    input  logic [xlen-1:0] rs1_data_i,
    input  logic [xlen-1:0] rs2_data_i,
    output logic            result_valid_o,
    output exec_result_t    result_o
);

    ctrl_word_t      ctrl;
    alu_op_e         alu_op;
    alu_flags_t      flags;
    logic            pc_src;
    logic            jalr_sel;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] pc_plus4;
    exec_result_t    rec;

    main_decoder u_main_decoder (
        .op_i       (instr_i.r.opcode),
        .funct3_i   (instr_i.r.funct3),
        .flags_i    (flags),
        .ctrl_o     (ctrl),
        .pc_src_o   (pc_src),
        .jalr_sel_o (jalr_sel)
    );

    alu_decoder u_alu_decoder (
        .alu_class_i (ctrl.alu_class),
        .funct3_i    (instr_i.r.funct3),
        .funct7_b5_i (instr_i.r.funct7[5]),
        .is_reg_op_i (!ctrl.alu_src_imm),
        .alu_op_o    (alu_op)
    );

    imm_extend u_imm_extend (
        .instr_i   (instr_i),
        .imm_src_i (ctrl.imm_src),
        .imm_o     (imm)
    );

    alu u_alu (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .result_o (alu_res),
        .flags_o  (flags)
    );

    assign alu_a    = ctrl.alu_a_pc ? pc_i : rs1_data_i;  // auipc
    assign alu_b    = ctrl.alu_src_imm ? imm : rs2_data_i;
    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        rec.store_data = rs2_data_i;
        rec.rd         = instr_i.r.rd;
        rec.reg_write  = ctrl.reg_write;
        rec.mem_write  = ctrl.mem_write;
        rec.wb_src     = ctrl.wb_src;
        if (jalr_sel) begin
            rec.next_pc = {alu_res[xlen-1:1], 1'b0};
        end else if (pc_src) begin
            rec.next_pc = pc_i + imm;
        end else begin
            rec.next_pc = pc_plus4;
        end
        case (ctrl.wb_src)
            wb_link: rec.result = pc_plus4;
            wb_imm:  rec.result = imm;
            default: rec.result = alu_res;  // also the load/store address
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_valid_o     <= 1'b0;
            result_o.reg_write <= 1'b0;
            result_o.mem_write <= 1'b0;
            result_o.next_pc   <= reset_pc;
        end else begin
            result_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                result_o <= rec;  // held while idle
            end
        end
    end

endmodule

// ==== exec_stage_properties.sv ====
`timescale 1ns/100ps

module exec_stage_properties import riscv_exec_pkg::*; (
    input logic         clk_i,
    input logic         rst_n_i,
    input logic         instr_valid_i,
    input logic         result_valid_o,
    input exec_result_t result_o
);

    int unsigned fail_count = 0;

    valid_low_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !result_valid_o)
        else begin
            $error("result_valid_o high after a reset cycle");
            fail_count++;
        end

    // fixed latency of one cycle
    valid_follows_strobe: assert property (@(posedge clk_i)
        rst_n_i |=> (result_valid_o == $past(instr_valid_i)))
        else begin
            $error("result_valid_o does not follow instr_valid_i by one cycle");
            fail_count++;
        end

    writes_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(result_o.reg_write && result_o.mem_write))
        else begin
            $error("reg_write and mem_write both set");
            fail_count++;
        end

    next_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_o.next_pc[0] == 1'b0)
        else begin
            $error("next_pc not 2-byte aligned");
            fail_count++;
        end

endmodule

bind exec_stage exec_stage_properties u_props (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
);

// ==== imm_extend.sv ====
`timescale 1ns/100ps

module imm_extend import riscv_exec_pkg::*; (
    input  instr_u          instr_i,
    input  imm_src_e        imm_src_i,
    output logic [xlen-1:0] imm_o
);

    always_comb begin
        case (imm_src_i)
            imm_i: imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
            imm_s: imm_o = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5,
                            instr_i.s.imm_4_0};
            imm_b: imm_o = {{20{instr_i.b.imm_12}}, instr_i.b.imm_11,
                            instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
            imm_u: imm_o = {instr_i.u.imm_31_12, 12'b0};
            imm_j: imm_o = {{12{instr_i.j.imm_20}}, instr_i.j.imm_19_12,
                            instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== main_decoder.sv ====
`timescale 1ns/100ps

module main_decoder import riscv_exec_pkg::*; (
    input  opcode_e    op_i,
    input  logic [2:0] funct3_i,
    input  alu_flags_t flags_i,    // from the branch subtract
    output ctrl_word_t ctrl_o,
    output logic       pc_src_o,   // take pc + imm
    output logic       jalr_sel_o  // take rs1 + imm
);

    logic taken;

    always_comb begin
        // safe default, also used for unknown opcodes
        ctrl_o.reg_write   = 1'b0;
        ctrl_o.mem_write   = 1'b0;
        ctrl_o.mem_read    = 1'b0;
        ctrl_o.alu_src_imm = 1'b0;
        ctrl_o.alu_a_pc    = 1'b0;
        ctrl_o.imm_src     = imm_i;
        ctrl_o.alu_class   = alu_add;
        ctrl_o.wb_src      = wb_alu;
        ctrl_o.branch      = 1'b0;
        ctrl_o.jal         = 1'b0;
        ctrl_o.jalr        = 1'b0;
        case (op_i)
            op_load: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.wb_src      = wb_mem;
            end
            op_store: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_src     = imm_s;
            end
            op_alu: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_class = alu_func;
            end
            op_alu_imm: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_class   = alu_func;
            end
            op_branch: begin
                ctrl_o.imm_src   = imm_b;
                ctrl_o.alu_class = alu_cmp;
                ctrl_o.branch    = 1'b1;
            end
            op_jal: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.imm_src   = imm_j;
                ctrl_o.wb_src    = wb_link;
                ctrl_o.jal       = 1'b1;
            end
            op_jalr: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;  // alu forms rs1 + imm
                ctrl_o.wb_src      = wb_link;
                ctrl_o.jalr        = 1'b1;
            end
            op_lui: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.imm_src   = imm_u;
                ctrl_o.wb_src    = wb_imm;
            end
            op_auipc: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_a_pc    = 1'b1;
                ctrl_o.imm_src     = imm_u;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (funct3_i)
            3'b000:  taken = flags_i.zero;   // beq
            3'b001:  taken = !flags_i.zero;  // bne
            3'b100:  taken = flags_i.lt;     // blt
            3'b101:  taken = !flags_i.lt;    // bge
            3'b110:  taken = flags_i.ltu;    // bltu
            3'b111:  taken = !flags_i.ltu;   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign pc_src_o   = (ctrl_o.branch && taken) || ctrl_o.jal;
    assign jalr_sel_o = ctrl_o.jalr;

endmodule

// ==== riscv_exec.f ====
riscv_exec_pkg.sv
alu.sv
alu_decoder.sv
imm_extend.sv
main_decoder.sv
exec_stage.sv
exec_stage_properties.sv
tb_exec_stage.sv

// ==== riscv_exec_pkg.sv ====
package riscv_exec_pkg;

    localparam int xlen = 32;

    typedef enum logic [6:0] {
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_alu     = 7'b0110011,
        op_alu_imm = 7'b0010011,
        op_branch  = 7'b1100011,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_src_e;

    typedef enum logic [1:0] {
        alu_add,  // address add
        alu_cmp,  // branch compare
        alu_func  // from funct3 / funct7
    } alu_class_e;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and,
        op_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_link,  // pc + 4
        wb_imm    // lui
    } wb_src_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one instruction word, six ways of reading it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic       reg_write;
        logic       mem_write;
        logic       mem_read;
        logic       alu_src_imm;  // operand b is imm
        logic       alu_a_pc;     // operand a is pc
        imm_src_e   imm_src;
        alu_class_e alu_class;
        wb_src_e    wb_src;
        logic       branch;
        logic       jal;
        logic       jalr;
    } ctrl_word_t;

    typedef struct packed {
        logic zero;
        logic lt;
        logic ltu;
    } alu_flags_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        logic            reg_write;
        logic            mem_write;
        wb_src_e         wb_src;
    } exec_result_t;

endpackage

// ==== tb_exec_stage.sv ====
`timescale 1ns/100ps

module tb_exec_stage import riscv_exec_pkg::*; ();

    localparam logic [31:0] reset_pc     = 32'h0000_1000;
    localparam int          n_strobes    = 54;
    localparam int          limit_cycles = n_strobes * 2 + 50;

    logic         clk_i;
    logic         rst_n_i;
    logic         instr_valid_i;
    instr_u       instr_i;
    logic [31:0]  pc_i;
    logic [31:0]  rs1_data_i;
    logic [31:0]  rs2_data_i;
    logic         result_valid_o;
    exec_result_t result_o;

    integer seed      = 32'h64ab_089c;
    int     errors    = 0;
    int     checks    = 0;
    int     cycles    = 0;
    string  test_name = "none";

    exec_stage #(.reset_pc(reset_pc)) dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        while (cycles < limit_cycles) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // encoders use x1 for rs1 and x2 for rs2
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                          logic [6:0] op);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] isa_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic isa_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic exec_result_t make_exp(logic [31:0] res, logic [31:0] npc,
            logic [31:0] sd, logic [4:0] dst, logic rw, logic mw, wb_src_e wb);
        return '{result: res, next_pc: npc, store_data: sd, rd: dst, reg_write: rw,
                 mem_write: mw, wb_src: wb};
    endfunction

    task automatic check_result(exec_result_t got, exec_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: result_o = %h, expected %h", test_name, got, exp);
        end
    endtask

    task automatic check_bit(string sig, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: %s = %h, expected %h", test_name, sig, got, exp);
        end
    endtask

    task automatic check_word(string sig, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: %s = %h, expected %h", test_name, sig, got, exp);
        end
    endtask

    // called at edge + 1 ns and returns one edge later with the result in place
    task automatic issue(logic [31:0] word, logic [31:0] pc, logic [31:0] a, logic [31:0] b);
        instr_valid_i = 1'b1;
        instr_i       = word;
        pc_i          = pc;
        rs1_data_i    = a;
        rs2_data_i    = b;
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
        check_bit("result_valid_o", result_valid_o, 1'b1);
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        #1;
        check_bit("result_valid_o", result_valid_o, 1'b0);
    endtask

    task automatic end_test(int e0);
        $display("test %s: %0d errors", test_name, errors - e0);
    endtask

    task automatic test_reset();
        int           e0 = errors;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  pc;
        logic [11:0]  imm;
        exec_result_t exp;
        test_name = "reset";
        check_bit("result_valid_o", result_valid_o, 1'b0);
        check_bit("result_o.reg_write", result_o.reg_write, 1'b0);
        check_bit("result_o.mem_write", result_o.mem_write, 1'b0);
        check_word("result_o.next_pc", result_o.next_pc, reset_pc);
        // lone strobe, then a back to back pair
        for (int n = 0; n < 3; n++) begin
            a   = rnd();
            b   = rnd();
            pc  = rnd() & ~32'h3;
            imm = 12'(rnd());
            issue(enc_i(imm, 3'b000, 5'd5, 7'b0010011), pc, a, b);
            exp = make_exp(a + sext12(imm), pc + 32'd4, b, 5'd5, 1'b1, 1'b0, wb_alu);
            check_result(result_o, exp);
            if (n != 1) begin
                idle_cycle();
                check_result(result_o, exp);  // held while idle
            end
        end
        end_test(e0);
    endtask

    task automatic test_alu();
        int           e0 = errors;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  pc;
        logic [11:0]  imm;
        logic [4:0]   rd;
        logic [2:0]   f3;
        logic         alt;
        exec_result_t exp;
        test_name = "alu";
        for (int n = 0; n < 10; n++) begin
            a   = rnd();
            b   = rnd();
            pc  = rnd() & ~32'h3;
            rd  = 5'(rnd());
            f3  = (n < 8) ? 3'(n) : ((n == 8) ? 3'b000 : 3'b101);
            alt = (n >= 8);  // sub, sra
            issue(enc_r(alt ? 7'h20 : 7'h00, f3, rd), pc, a, b);
            exp = make_exp(isa_alu(f3, alt, a, b), pc + 32'd4, b, rd, 1'b1, 1'b0, wb_alu);
            check_result(result_o, exp);
        end
        for (int n = 0; n < 10; n++) begin
            a   = rnd();
            b   = rnd();
            pc  = rnd() & ~32'h3;
            rd  = 5'(rnd());
            f3  = (n < 8) ? 3'(n) : ((n == 8) ? 3'b101 : 3'b000);
            imm = 12'(rnd());
            if (f3 == 3'b001 || f3 == 3'b101) imm = {7'h00, imm[4:0]};  // shamt only
            if (n == 8) imm = {7'h20, imm[4:0]};  // srai
            if (n == 9) imm = {2'b01, imm[9:0]};  // bit 30 set yet still an add
            alt = (f3 == 3'b101) && imm[10];
            issue(enc_i(imm, f3, rd, 7'b0010011), pc, a, b);
            exp = make_exp(isa_alu(f3, alt, a, sext12(imm)), pc + 32'd4, b, rd,
                           1'b1, 1'b0, wb_alu);
            check_result(result_o, exp);
        end
        end_test(e0);
    endtask

    task automatic test_mem();
        int           e0 = errors;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  pc;
        logic [11:0]  imm;
        logic [4:0]   rd;
        exec_result_t exp;
        test_name = "load_store";
        for (int n = 0; n < 6; n++) begin
            a   = rnd();
            b   = rnd();
            pc  = rnd() & ~32'h3;
            rd  = 5'(rnd());
            imm = 12'(rnd());
            if (n < 3) begin
                issue(enc_i(imm, 3'b010, rd, 7'b0000011), pc, a, b);
                exp = make_exp(a + sext12(imm), pc + 32'd4, b, rd, 1'b1, 1'b0, wb_mem);
            end else begin
                issue(enc_s(imm), pc, a, b);
                exp = make_exp(a + sext12(imm), pc + 32'd4, b, imm[4:0], 1'b0, 1'b1, wb_alu);
            end
            check_result(result_o, exp);
        end
        end_test(e0);
    endtask

    task automatic test_branch();
        int           e0 = errors;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  pc;
        logic [31:0]  pos;
        logic [31:0]  neg;
        logic [31:0]  nxt;
        logic [12:0]  boff;
        logic [2:0]   f3;
        exec_result_t exp;
        test_name = "branch";
        for (int n = 0; n < 24; n++) begin
            f3 = 3'(n / 3);
            if (f3 == 3'b010 || f3 == 3'b011) continue;  // not branch funct3
            pos  = rnd() & 32'h7fff_ffff;
            neg  = rnd() | 32'h8000_0000;  // also large unsigned
            pc   = rnd() & ~32'h3;
            boff = {12'(rnd()), 1'b0};
            case (n % 3)
                0: begin
                    a = pos;
                    b = pos;
                end
                1: begin
                    a = neg;
                    b = pos;
                end
                default: begin
                    a = pos;
                    b = neg;
                end
            endcase
            nxt = isa_taken(f3, a, b) ? pc + {{19{boff[12]}}, boff} : pc + 32'd4;
            issue(enc_b(boff, f3), pc, a, b);
            exp = make_exp(a - b, nxt, b, {boff[4:1], boff[11]}, 1'b0, 1'b0, wb_alu);
            check_result(result_o, exp);
        end
        end_test(e0);
    endtask

    task automatic test_jump();
        int           e0 = errors;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  pc;
        logic [20:0]  joff;
        logic [19:0]  u;
        logic [11:0]  imm;
        logic [4:0]   rd;
        exec_result_t exp;
        test_name = "jump_upper";
        a    = rnd();
        b    = rnd();
        pc   = rnd() & ~32'h3;
        rd   = 5'(rnd());
        joff = {20'(rnd()), 1'b0};
        issue(enc_j(joff, rd), pc, a, b);
        exp = make_exp(pc + 32'd4, pc + {{11{joff[20]}}, joff}, b, rd, 1'b1, 1'b0, wb_link);
        check_result(result_o, exp);
        for (int n = 0; n < 2; n++) begin
            a   = rnd() | 32'(n == 0);  // odd target first
            imm = 12'(rnd()) & 12'hffe;
            issue(enc_i(imm, 3'b000, rd, 7'b1100111), pc, a, b);
            exp = make_exp(pc + 32'd4, (a + sext12(imm)) & ~32'h1, b, rd, 1'b1, 1'b0, wb_link);
            check_result(result_o, exp);
        end
        u = 20'(rnd());
        issue({u, rd, 7'b0110111}, pc, a, b);
        exp = make_exp({u, 12'b0}, pc + 32'd4, b, rd, 1'b1, 1'b0, wb_imm);
        check_result(result_o, exp);
        issue({u, rd, 7'b0010111}, pc, a, b);
        exp = make_exp(pc + {u, 12'b0}, pc + 32'd4, b, rd, 1'b1, 1'b0, wb_alu);
        check_result(result_o, exp);
        end_test(e0);
    endtask

    task automatic test_illegal();
        int          e0 = errors;
        logic [31:0] pc;
        test_name = "illegal";
        for (int n = 0; n < 2; n++) begin
            pc = rnd() & ~32'h3;
            issue({25'(rnd()), ((n == 0) ? 7'h7f : 7'h0b)}, pc, rnd(), rnd());
            check_bit("result_o.reg_write", result_o.reg_write, 1'b0);
            check_bit("result_o.mem_write", result_o.mem_write, 1'b0);
            check_word("result_o.next_pc", result_o.next_pc, pc + 32'd4);
        end
        end_test(e0);
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        test_reset();
        test_alu();
        test_mem();
        test_branch();
        test_jump();
        test_illegal();
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 dut.u_props.fail_count);
        if (errors == 0 && dut.u_props.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
